//--- rtl/csr_pkg.sv
package csr_pkg;

    typedef logic [11:0] csr_addr_t;
    typedef logic [31:0] xlen_t;

    // encodings follow the low two bits of funct3.
    typedef enum logic [1:0] {
        csr_rw = 2'b01,
        csr_rs = 2'b10,
        csr_rc = 2'b11
    } csr_op_e;

    localparam logic [1:0] machine_mode = 2'b11;

    // --------------------
    // addresses
    // --------------------
    localparam csr_addr_t mvendorid_addr  = 12'hf11;
    localparam csr_addr_t marchid_addr    = 12'hf12;
    localparam csr_addr_t mimpid_addr     = 12'hf13;
    localparam csr_addr_t mhartid_addr    = 12'hf14;

    localparam csr_addr_t mstatus_addr    = 12'h300;
    localparam csr_addr_t misa_addr       = 12'h301;
    localparam csr_addr_t mie_addr        = 12'h304;
    localparam csr_addr_t mtvec_addr      = 12'h305;
    localparam csr_addr_t mcounteren_addr = 12'h306;

    localparam csr_addr_t mscratch_addr   = 12'h340;
    localparam csr_addr_t mepc_addr       = 12'h341;
    localparam csr_addr_t mcause_addr     = 12'h342;
    localparam csr_addr_t mtval_addr      = 12'h343;
    localparam csr_addr_t mip_addr        = 12'h344;

    // --------------------
    // constant registers
    // --------------------
    localparam xlen_t mvendorid_val = 32'h0000_0000;
    localparam xlen_t marchid_val   = 32'h0000_0000;
    localparam xlen_t mimpid_val    = 32'h0000_0001;
    localparam xlen_t mhartid_val   = 32'h0000_0000;
    // mxl of 1 selects 32 bits and only the I extension is present.
    localparam xlen_t misa_val      = 32'h4000_0100;

    // --------------------
    // fields and masks
    // --------------------
    localparam int mstatus_mie_bit  = 3;
    localparam int mstatus_mpie_bit = 7;
    localparam int mstatus_mpp_lo   = 11;
    localparam int mstatus_mpp_hi   = 12;

    localparam int msi_bit = 3;
    localparam int mti_bit = 7;
    localparam int mei_bit = 11;

    localparam xlen_t mstatus_wmask    = 32'h0000_0088;
    localparam xlen_t mie_wmask        = 32'h0000_0888;
    localparam xlen_t mtvec_wmask      = 32'hffff_fffc;
    localparam xlen_t mepc_wmask       = 32'hffff_fffc;
    localparam xlen_t mcounteren_wmask = 32'h0000_0007;

endpackage

//--- rtl/csr_access.sv
`timescale 1ns/10ps

module csr_access import csr_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    input  logic      csr_valid,
    input  csr_op_e   csr_op,
    input  csr_addr_t csr_addr,
    input  xlen_t     csr_wdata,

    input  xlen_t     mstatus,
    input  xlen_t     mie,
    input  xlen_t     mtvec,
    input  xlen_t     mcounteren,
    input  xlen_t     mscratch,
    input  xlen_t     mepc,
    input  xlen_t     mcause,
    input  xlen_t     mtval,
    input  xlen_t     mip,

    output logic      csr_rvalid,
    output xlen_t     csr_rdata,
    output logic      csr_illegal,

    output xlen_t     wr_data,
    output logic      mstatus_we,
    output logic      mie_we,
    output logic      mtvec_we,
    output logic      mcounteren_we,
    output logic      mscratch_we,
    output logic      mepc_we,
    output logic      mcause_we,
    output logic      mtval_we
);

    xlen_t old_value;
    logic  known;
    logic  read_only;
    logic  is_write;
    logic  illegal;
    logic  write_ok;

    // --------------------
    // address decode
    // --------------------
    always_comb begin
        old_value = '0;
        known     = 1'b1;
        read_only = 1'b0;
        case (csr_addr)
            mvendorid_addr: begin
                old_value = mvendorid_val;
                read_only = 1'b1;
            end
            marchid_addr: begin
                old_value = marchid_val;
                read_only = 1'b1;
            end
            mimpid_addr: begin
                old_value = mimpid_val;
                read_only = 1'b1;
            end
            mhartid_addr: begin
                old_value = mhartid_val;
                read_only = 1'b1;
            end
            mstatus_addr:    old_value = mstatus;
            // misa accepts writes and keeps its value.
            misa_addr:       old_value = misa_val;
            mie_addr:        old_value = mie;
            mtvec_addr:      old_value = mtvec;
            mcounteren_addr: old_value = mcounteren;
            mscratch_addr:   old_value = mscratch;
            mepc_addr:       old_value = mepc;
            mcause_addr:     old_value = mcause;
            mtval_addr:      old_value = mtval;
            mip_addr: begin
                old_value = mip;
                read_only = 1'b1;
            end
            default:         known = 1'b0;
        endcase
    end

    // set and clear with zero data are pure reads.
    assign is_write = (csr_op == csr_rw) || (csr_wdata != '0);
    assign illegal  = !known || (read_only && is_write);
    assign write_ok = csr_valid && is_write && !illegal;

    always_comb begin
        case (csr_op)
            csr_rs:  wr_data = old_value | csr_wdata;
            csr_rc:  wr_data = old_value & ~csr_wdata;
            default: wr_data = csr_wdata;
        endcase
    end

    assign mstatus_we    = write_ok && (csr_addr == mstatus_addr);
    assign mie_we        = write_ok && (csr_addr == mie_addr);
    assign mtvec_we      = write_ok && (csr_addr == mtvec_addr);
    assign mcounteren_we = write_ok && (csr_addr == mcounteren_addr);
    assign mscratch_we   = write_ok && (csr_addr == mscratch_addr);
    assign mepc_we       = write_ok && (csr_addr == mepc_addr);
    assign mcause_we     = write_ok && (csr_addr == mcause_addr);
    assign mtval_we      = write_ok && (csr_addr == mtval_addr);

    // --------------------
    // response
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            csr_rvalid  <= 1'b0;
            csr_illegal <= 1'b0;
        end else begin
            csr_rvalid  <= csr_valid;
            csr_illegal <= csr_valid && illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (csr_valid) begin
            csr_rdata <= illegal ? '0 : old_value;
        end
    end

endmodule

//--- rtl/m_trap_setup_regs.sv
`timescale 1ns/10ps

module m_trap_setup_regs import csr_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,

    input  xlen_t wr_data,
    input  logic  mstatus_we,
    input  logic  mie_we,
    input  logic  mtvec_we,
    input  logic  mcounteren_we,

    input  logic  trap_valid,
    input  logic  mret_valid,

    output xlen_t mstatus,
    output xlen_t mie,
    output xlen_t mtvec,
    output xlen_t mcounteren
);

    // only the writable bits of mstatus are stored here.
    xlen_t mstatus_q;

    // --------------------
    // mstatus
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_q <= '0;
        end else if (trap_valid) begin
            mstatus_q[mstatus_mpie_bit] <= mstatus_q[mstatus_mie_bit];
            mstatus_q[mstatus_mie_bit]  <= 1'b0;
        end else if (mret_valid) begin
            mstatus_q[mstatus_mie_bit]  <= mstatus_q[mstatus_mpie_bit];
            mstatus_q[mstatus_mpie_bit] <= 1'b1;
        end else if (mstatus_we) begin
            mstatus_q <= wr_data & mstatus_wmask;
        end
    end

    // mpp is hardwired to machine mode.
    always_comb begin
        mstatus = mstatus_q;
        mstatus[mstatus_mpp_hi:mstatus_mpp_lo] = machine_mode;
    end

    // --------------------
    // mie, mtvec, mcounteren
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mie <= '0;
        end else if (mie_we) begin
            mie <= wr_data & mie_wmask;
        end
    end

    // direct mode only, so the mode field stays zero.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec <= '0;
        end else if (mtvec_we) begin
            mtvec <= wr_data & mtvec_wmask;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mcounteren <= '0;
        end else if (mcounteren_we) begin
            mcounteren <= wr_data & mcounteren_wmask;
        end
    end

endmodule

//--- rtl/m_trap_handling_regs.sv
`timescale 1ns/10ps

module m_trap_handling_regs import csr_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,

    input  xlen_t wr_data,
    input  logic  mscratch_we,
    input  logic  mepc_we,
    input  logic  mcause_we,
    input  logic  mtval_we,

    input  logic  trap_valid,
    input  xlen_t trap_cause,
    input  xlen_t trap_pc,
    input  xlen_t trap_tval,

    input  logic  irq_ext,
    input  logic  irq_timer,
    input  logic  irq_soft,

    input  xlen_t mie,
    input  logic  mstatus_mie,

    output xlen_t mscratch,
    output xlen_t mepc,
    output xlen_t mcause,
    output xlen_t mtval,
    output xlen_t mip,
    output logic  irq_pending
);

    xlen_t mip_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mscratch <= '0;
        end else if (mscratch_we) begin
            mscratch <= wr_data;
        end
    end

    // --------------------
    // trap capture
    // --------------------
    // a trap wins over a csr write in the same cycle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc   <= '0;
            mcause <= '0;
            mtval  <= '0;
        end else if (trap_valid) begin
            mepc   <= trap_pc & mepc_wmask;
            mcause <= trap_cause;
            mtval  <= trap_tval;
        end else begin
            if (mepc_we) begin
                mepc <= wr_data & mepc_wmask;
            end
            if (mcause_we) begin
                mcause <= wr_data;
            end
            if (mtval_we) begin
                mtval <= wr_data;
            end
        end
    end

    // --------------------
    // interrupts
    // --------------------
    always_comb begin
        mip_next          = '0;
        mip_next[mei_bit] = irq_ext;
        mip_next[mti_bit] = irq_timer;
        mip_next[msi_bit] = irq_soft;
    end

    // lines are sampled every cycle with one cycle of latency.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mip <= '0;
        end else begin
            mip <= mip_next;
        end
    end

    assign irq_pending = mstatus_mie && ((mip & mie) != '0);

endmodule

//--- rtl/csrs.sv
`timescale 1ns/10ps

module csrs import csr_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    input  logic      csr_valid,
    input  csr_op_e   csr_op,
    input  csr_addr_t csr_addr,
    input  xlen_t     csr_wdata,
    output logic      csr_rvalid,
    output xlen_t     csr_rdata,
    output logic      csr_illegal,

    input  logic      trap_valid,
    input  xlen_t     trap_cause,
    input  xlen_t     trap_pc,
    input  xlen_t     trap_tval,
    output xlen_t     trap_vector,

    input  logic      mret_valid,
    output xlen_t     epc,

    input  logic      irq_ext,
    input  logic      irq_timer,
    input  logic      irq_soft,
    output logic      irq_pending
);

    xlen_t mstatus;
    xlen_t mie;
    xlen_t mtvec;
    xlen_t mcounteren;
    xlen_t mscratch;
    xlen_t mepc;
    xlen_t mcause;
    xlen_t mtval;
    xlen_t mip;

    xlen_t wr_data;
    logic  mstatus_we;
    logic  mie_we;
    logic  mtvec_we;
    logic  mcounteren_we;
    logic  mscratch_we;
    logic  mepc_we;
    logic  mcause_we;
    logic  mtval_we;

    // --------------------
    // access path
    // --------------------
    csr_access u_access (
        .clk           (clk),
        .rst_n         (rst_n),
        .csr_valid     (csr_valid),
        .csr_op        (csr_op),
        .csr_addr      (csr_addr),
        .csr_wdata     (csr_wdata),
        .mstatus       (mstatus),
        .mie           (mie),
        .mtvec         (mtvec),
        .mcounteren    (mcounteren),
        .mscratch      (mscratch),
        .mepc          (mepc),
        .mcause        (mcause),
        .mtval         (mtval),
        .mip           (mip),
        .csr_rvalid    (csr_rvalid),
        .csr_rdata     (csr_rdata),
        .csr_illegal   (csr_illegal),
        .wr_data       (wr_data),
        .mstatus_we    (mstatus_we),
        .mie_we        (mie_we),
        .mtvec_we      (mtvec_we),
        .mcounteren_we (mcounteren_we),
        .mscratch_we   (mscratch_we),
        .mepc_we       (mepc_we),
        .mcause_we     (mcause_we),
        .mtval_we      (mtval_we)
    );

    // --------------------
    // register blocks
    // --------------------
    m_trap_setup_regs u_setup (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_data       (wr_data),
        .mstatus_we    (mstatus_we),
        .mie_we        (mie_we),
        .mtvec_we      (mtvec_we),
        .mcounteren_we (mcounteren_we),
        .trap_valid    (trap_valid),
        .mret_valid    (mret_valid),
        .mstatus       (mstatus),
        .mie           (mie),
        .mtvec         (mtvec),
        .mcounteren    (mcounteren)
    );

    m_trap_handling_regs u_handling (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_data     (wr_data),
        .mscratch_we (mscratch_we),
        .mepc_we     (mepc_we),
        .mcause_we   (mcause_we),
        .mtval_we    (mtval_we),
        .trap_valid  (trap_valid),
        .trap_cause  (trap_cause),
        .trap_pc     (trap_pc),
        .trap_tval   (trap_tval),
        .irq_ext     (irq_ext),
        .irq_timer   (irq_timer),
        .irq_soft    (irq_soft),
        .mie         (mie),
        .mstatus_mie (mstatus[mstatus_mie_bit]),
        .mscratch    (mscratch),
        .mepc        (mepc),
        .mcause      (mcause),
        .mtval       (mtval),
        .mip         (mip),
        .irq_pending (irq_pending)
    );

    // direct mode sends every trap to the base address.
    assign trap_vector = mtvec;
    assign epc         = mepc;

endmodule

//--- include/csrs_tb_vectors.svh
function automatic void fill_table();
    // irq levels are {ext, timer, soft}.
    // access_row(op, addr, wdata, irq, rdata, illegal, pending).
    // read_row(addr, irq, rdata, pending).

    // reset values.
    rows.push_back(read_row(mvendorid_addr, 3'b000, mvendorid_val, 1'b0));
    rows.push_back(read_row(marchid_addr, 3'b000, marchid_val, 1'b0));
    rows.push_back(read_row(mimpid_addr, 3'b000, mimpid_val, 1'b0));
    rows.push_back(read_row(mhartid_addr, 3'b000, mhartid_val, 1'b0));
    rows.push_back(read_row(misa_addr, 3'b000, misa_val, 1'b0));
    rows.push_back(read_row(mstatus_addr, 3'b000, 32'h0000_1800, 1'b0));
    rows.push_back(read_row(mie_addr, 3'b000, 32'h0, 1'b0));
    rows.push_back(read_row(mtvec_addr, 3'b000, 32'h0, 1'b0));
    rows.push_back(read_row(mcounteren_addr, 3'b000, 32'h0, 1'b0));
    rows.push_back(read_row(mscratch_addr, 3'b000, 32'h0, 1'b0));
    rows.push_back(read_row(mepc_addr, 3'b000, 32'h0, 1'b0));
    rows.push_back(read_row(mcause_addr, 3'b000, 32'h0, 1'b0));
    rows.push_back(read_row(mtval_addr, 3'b000, 32'h0, 1'b0));
    rows.push_back(read_row(mip_addr, 3'b000, 32'h0, 1'b0));

    // --------------------
    // write, set and clear
    // --------------------
    rows.push_back(access_row(csr_rw, mscratch_addr, 32'h1234_5678, 3'b000,
        32'h0, 1'b0, 1'b0));
    rows.push_back(access_row(csr_rs, mscratch_addr, 32'h0000_00f0, 3'b000,
        32'h1234_5678, 1'b0, 1'b0));
    rows.push_back(access_row(csr_rc, mscratch_addr, 32'h1200_0008, 3'b000,
        32'h1234_56f8, 1'b0, 1'b0));
    rows.push_back(read_row(mscratch_addr, 3'b000, 32'h0034_56f0, 1'b0));
    rows.push_back(access_row(csr_rw, mie_addr, 32'hffff_ffff, 3'b000, 32'h0, 1'b0, 1'b0));
    rows.push_back(access_row(csr_rc, mie_addr, 32'h0000_0080, 3'b000,
        32'h0000_0888, 1'b0, 1'b0));
    rows.push_back(read_row(mie_addr, 3'b000, 32'h0000_0808, 1'b0));
    rows.push_back(access_row(csr_rw, mtvec_addr, 32'h8000_0103, 3'b000, 32'h0, 1'b0, 1'b0));
    rows.push_back(access_row(csr_rs, mtvec_addr, 32'h0000_0200, 3'b000,
        32'h8000_0100, 1'b0, 1'b0));
    rows.push_back(read_row(mtvec_addr, 3'b000, 32'h8000_0300, 1'b0));
    rows.push_back(access_row(csr_rs, mstatus_addr, 32'h0000_0008, 3'b000,
        32'h0000_1800, 1'b0, 1'b0));
    rows.push_back(access_row(csr_rw, mstatus_addr, 32'hffff_ffff, 3'b000,
        32'h0000_1808, 1'b0, 1'b0));
    rows.push_back(access_row(csr_rc, mstatus_addr, 32'h0000_0080, 3'b000,
        32'h0000_1888, 1'b0, 1'b0));
    rows.push_back(read_row(mstatus_addr, 3'b000, 32'h0000_1808, 1'b0));
    rows.push_back(access_row(csr_rw, mcounteren_addr, 32'hffff_ffff, 3'b000,
        32'h0, 1'b0, 1'b0));
    rows.push_back(read_row(mcounteren_addr, 3'b000, 32'h0000_0007, 1'b0));
    rows.push_back(access_row(csr_rw, mepc_addr, 32'h0000_2223, 3'b000, 32'h0, 1'b0, 1'b0));
    rows.push_back(read_row(mepc_addr, 3'b000, 32'h0000_2220, 1'b0));
    rows.push_back(access_row(csr_rw, mcause_addr, 32'h8000_0007, 3'b000,
        32'h0, 1'b0, 1'b0));
    rows.push_back(access_row(csr_rw, mtval_addr, 32'h0000_0bad, 3'b000, 32'h0, 1'b0, 1'b0));
    rows.push_back(read_row(mcause_addr, 3'b000, 32'h8000_0007, 1'b0));
    rows.push_back(read_row(mtval_addr, 3'b000, 32'h0000_0bad, 1'b0));

    // illegal accesses.
    rows.push_back(access_row(csr_rs, 12'h7c0, 32'h0, 3'b000, 32'h0, 1'b1, 1'b0));
    rows.push_back(access_row(csr_rw, mvendorid_addr, 32'hdead_beef, 3'b000,
        32'h0, 1'b1, 1'b0));
    rows.push_back(access_row(csr_rs, mip_addr, 32'h0000_0800, 3'b000, 32'h0, 1'b1, 1'b0));
    rows.push_back(read_row(mip_addr, 3'b000, 32'h0, 1'b0));
    rows.push_back(read_row(mscratch_addr, 3'b000, 32'h0034_56f0, 1'b0));

    // --------------------
    // trap and mret
    // --------------------
    rows.push_back(trap_row(32'h0000_000b, 32'h0000_4567, 32'h0000_abcd, 3'b000,
        32'h8000_0300, 1'b0));
    rows.push_back(read_row(mepc_addr, 3'b000, 32'h0000_4564, 1'b0));
    rows.push_back(read_row(mcause_addr, 3'b000, 32'h0000_000b, 1'b0));
    rows.push_back(read_row(mtval_addr, 3'b000, 32'h0000_abcd, 1'b0));
    rows.push_back(read_row(mstatus_addr, 3'b000, 32'h0000_1880, 1'b0));
    rows.push_back(mret_row(3'b000, 32'h0000_4564, 1'b0));
    rows.push_back(read_row(mstatus_addr, 3'b000, 32'h0000_1888, 1'b0));

    // external interrupt, then global disable.
    rows.push_back(access_row(csr_rw, mie_addr, 32'h0000_0800, 3'b000,
        32'h0000_0808, 1'b0, 1'b0));
    rows.push_back(irq_row(3'b100, 1'b1));
    rows.push_back(read_row(mip_addr, 3'b100, 32'h0000_0800, 1'b1));
    rows.push_back(access_row(csr_rc, mstatus_addr, 32'h0000_0008, 3'b100,
        32'h0000_1888, 1'b0, 1'b0));
    rows.push_back(irq_row(3'b000, 1'b0));

    // timer and software interrupts while mie masks the external one.
    rows.push_back(access_row(csr_rw, mie_addr, 32'h0000_0088, 3'b000,
        32'h0000_0800, 1'b0, 1'b0));
    rows.push_back(access_row(csr_rs, mstatus_addr, 32'h0000_0008, 3'b000,
        32'h0000_1880, 1'b0, 1'b0));
    rows.push_back(irq_row(3'b010, 1'b1));
    rows.push_back(read_row(mip_addr, 3'b010, 32'h0000_0080, 1'b1));
    rows.push_back(irq_row(3'b001, 1'b1));
    rows.push_back(read_row(mip_addr, 3'b001, 32'h0000_0008, 1'b1));
    rows.push_back(irq_row(3'b100, 1'b0));
endfunction

//--- verification/csrs_tb.sv
`timescale 1ns/10ps

module csrs_tb import csr_pkg::*; ();

    typedef enum logic [1:0] {
        kind_access,
        kind_trap,
        kind_mret,
        kind_irq
    } row_kind_e;

    typedef struct packed {
        row_kind_e  kind;
        csr_op_e    op;
        csr_addr_t  addr;
        xlen_t      data;
        xlen_t      cause;
        xlen_t      pc;
        xlen_t      tval;
        logic [2:0] irq;
        xlen_t      exp_rdata;
        logic       exp_illegal;
        logic       exp_pending;
        // trap_vector on a trap row, epc on an mret row.
        xlen_t      exp_aux;
    } row_t;

    logic      clk;
    logic      rst_n;
    logic      csr_valid;
    csr_op_e   csr_op;
    csr_addr_t csr_addr;
    xlen_t     csr_wdata;
    logic      csr_rvalid;
    xlen_t     csr_rdata;
    logic      csr_illegal;
    logic      trap_valid;
    xlen_t     trap_cause;
    xlen_t     trap_pc;
    xlen_t     trap_tval;
    xlen_t     trap_vector;
    logic      mret_valid;
    xlen_t     epc;
    logic      irq_ext;
    logic      irq_timer;
    logic      irq_soft;
    logic      irq_pending;

    row_t rows[$];
    int   error_count = 0;
    int   row_count = 0;
    int   cycle_count = 0;

    csrs u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_valid   (csr_valid),
        .csr_op      (csr_op),
        .csr_addr    (csr_addr),
        .csr_wdata   (csr_wdata),
        .csr_rvalid  (csr_rvalid),
        .csr_rdata   (csr_rdata),
        .csr_illegal (csr_illegal),
        .trap_valid  (trap_valid),
        .trap_cause  (trap_cause),
        .trap_pc     (trap_pc),
        .trap_tval   (trap_tval),
        .trap_vector (trap_vector),
        .mret_valid  (mret_valid),
        .epc         (epc),
        .irq_ext     (irq_ext),
        .irq_timer   (irq_timer),
        .irq_soft    (irq_soft),
        .irq_pending (irq_pending)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // --------------------
    // row builders
    // --------------------
    function automatic row_t access_row(input csr_op_e op, input csr_addr_t addr,
                                        input xlen_t data, input logic [2:0] irq,
                                        input xlen_t rdata, input logic illegal,
                                        input logic pending);
        row_t r;
        r = '0;
        r.kind        = kind_access;
        r.op          = op;
        r.addr        = addr;
        r.data        = data;
        r.irq         = irq;
        r.exp_rdata   = rdata;
        r.exp_illegal = illegal;
        r.exp_pending = pending;
        return r;
    endfunction

    // set with zero data reads without writing.
    function automatic row_t read_row(input csr_addr_t addr, input logic [2:0] irq,
                                      input xlen_t rdata, input logic pending);
        return access_row(csr_rs, addr, 32'h0, irq, rdata, 1'b0, pending);
    endfunction

    function automatic row_t trap_row(input xlen_t cause, input xlen_t pc, input xlen_t tval,
                                      input logic [2:0] irq, input xlen_t vector,
                                      input logic pending);
        row_t r;
        r = '0;
        r.kind        = kind_trap;
        r.op          = csr_rs;
        r.cause       = cause;
        r.pc          = pc;
        r.tval        = tval;
        r.irq         = irq;
        r.exp_pending = pending;
        r.exp_aux     = vector;
        return r;
    endfunction

    function automatic row_t mret_row(input logic [2:0] irq, input xlen_t ret_pc,
                                      input logic pending);
        row_t r;
        r = '0;
        r.kind        = kind_mret;
        r.op          = csr_rs;
        r.irq         = irq;
        r.exp_pending = pending;
        r.exp_aux     = ret_pc;
        return r;
    endfunction

    function automatic row_t irq_row(input logic [2:0] irq, input logic pending);
        row_t r;
        r = '0;
        r.kind        = kind_irq;
        r.op          = csr_rs;
        r.irq         = irq;
        r.exp_pending = pending;
        return r;
    endfunction

    `include "csrs_tb_vectors.svh"

    // --------------------
    // drive and check
    // --------------------
    task automatic drive_row(input row_t r);
        csr_valid <= (r.kind == kind_access);
        csr_op    <= r.op;
        csr_addr  <= r.addr;
        if (r.kind == kind_access) begin
            csr_wdata <= r.data;
        end else begin
            csr_wdata <= $urandom;
        end
        trap_valid <= (r.kind == kind_trap);
        trap_cause <= r.cause;
        trap_pc    <= r.pc;
        trap_tval  <= r.tval;
        mret_valid <= (r.kind == kind_mret);
        // irq levels stay until the next row.
        irq_ext    <= r.irq[2];
        irq_timer  <= r.irq[1];
        irq_soft   <= r.irq[0];
    endtask

    task automatic release_inputs();
        csr_valid  <= 1'b0;
        trap_valid <= 1'b0;
        mret_valid <= 1'b0;
    endtask

    task automatic report_mismatch(input int idx, input string name,
                                   input xlen_t expected, input xlen_t actual);
        error_count++;
        $display("Fail at %0t row %0d: %s expected 0x%h, got 0x%h",
                 $time, idx, name, expected, actual);
    endtask

    task automatic check_row(input int idx, input row_t r);
        row_count++;
        if (r.kind == kind_access) begin
            if (csr_rvalid !== 1'b1) begin
                report_mismatch(idx, "csr_rvalid", 32'h1, xlen_t'(csr_rvalid));
            end
            if (csr_illegal !== r.exp_illegal) begin
                report_mismatch(idx, "csr_illegal", xlen_t'(r.exp_illegal),
                                xlen_t'(csr_illegal));
            end
            if (csr_rdata !== r.exp_rdata) begin
                report_mismatch(idx, "csr_rdata", r.exp_rdata, csr_rdata);
            end
        end else begin
            if (csr_rvalid !== 1'b0) begin
                report_mismatch(idx, "csr_rvalid", 32'h0, xlen_t'(csr_rvalid));
            end
            if (csr_illegal !== 1'b0) begin
                report_mismatch(idx, "csr_illegal", 32'h0, xlen_t'(csr_illegal));
            end
        end
        if (r.kind == kind_trap && trap_vector !== r.exp_aux) begin
            report_mismatch(idx, "trap_vector", r.exp_aux, trap_vector);
        end
        if (r.kind == kind_mret && epc !== r.exp_aux) begin
            report_mismatch(idx, "epc", r.exp_aux, epc);
        end
        if (irq_pending !== r.exp_pending) begin
            report_mismatch(idx, "irq_pending", xlen_t'(r.exp_pending), xlen_t'(irq_pending));
        end
    endtask

    // each row takes two cycles, so four per row leaves ample room.
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= rows.size() * 4 + 50) begin
            $display("Timeout after %0d cycles, the table did not complete", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(97));
        rst_n      = 1'b0;
        csr_valid  = 1'b0;
        csr_op     = csr_rs;
        csr_addr   = '0;
        csr_wdata  = '0;
        trap_valid = 1'b0;
        trap_cause = '0;
        trap_pc    = '0;
        trap_tval  = '0;
        mret_valid = 1'b0;
        irq_ext    = 1'b0;
        irq_timer  = 1'b0;
        irq_soft   = 1'b0;
        fill_table();

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // response is registered, so it is checked one edge after the request.
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            drive_row(rows[i]);
            @(posedge clk);
            release_inputs();
            @(negedge clk);
            check_row(i, rows[i]);
        end

        $display("Rows checked: %0d, errors: %0d", row_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+include
rtl/csr_pkg.sv
rtl/csr_access.sv
rtl/m_trap_setup_regs.sv
rtl/m_trap_handling_regs.sv
rtl/csrs.sv
verification/csrs_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module csrs_tb -o csrs_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/csrs_sim)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation passed"; then
    exit 0
else
    exit 1
fi
